// File: design/mem_line_pkg.sv
package mem_line_pkg;

    // byte address as seen by both caches
    typedef logic [31:0] addr_t;

    // one full cache line, 32 bytes
    typedef logic [255:0] line_t;

    // low address bits that select a byte inside a line
    localparam int LINE_OFFSET_BITS = 5;

    // who currently holds the shared line port
    typedef enum logic [1:0] {
        OWN_NONE   = 2'd0,
        OWN_ICACHE = 2'd1,
        OWN_DCACHE = 2'd2
    } owner_t;

endpackage

// File: design/mem_burst_pkg.sv
package mem_burst_pkg;

    // one data beat on the external memory port
    typedef logic [63:0] beat_t;

    // beats needed to move a full line
    localparam int BURST_BEATS = 4;

    // counts beats within one burst
    typedef logic [$clog2(BURST_BEATS)-1:0] beat_idx_t;

endpackage

// File: design/line_arbiter.sv
`timescale 1ns/1ps

module line_arbiter
    import mem_line_pkg::*;
#(
    parameter bit DCACHE_FIRST = 1'b1
) (
    input  logic   clk,
    input  logic   rst,

    // instruction cache, read only
    input  logic   icache_read,
    input  addr_t  icache_address,
    output logic   icache_resp,
    output line_t  icache_rdata,

    // data cache
    input  logic   dcache_read,
    input  logic   dcache_write,
    input  addr_t  dcache_address,
    input  line_t  dcache_wdata,
    output logic   dcache_resp,
    output line_t  dcache_rdata,

    // shared port towards the cacheline adapter
    input  logic   adapter_resp,
    input  line_t  adapter_rdata,
    output logic   adapter_read,
    output logic   adapter_write,
    output addr_t  adapter_address,
    output line_t  adapter_wdata
);

    owner_t state;
    owner_t next_state;

    logic icache_req;
    logic dcache_req;

    assign icache_req = icache_read;
    assign dcache_req = dcache_read | dcache_write;

    // grant selection, only evaluated from idle
    always_comb begin
        next_state = state;
        case (state)
            OWN_NONE: begin
                if (icache_req && dcache_req) begin
                    next_state = DCACHE_FIRST ? OWN_DCACHE : OWN_ICACHE;
                end else if (dcache_req) begin
                    next_state = OWN_DCACHE;
                end else if (icache_req) begin
                    next_state = OWN_ICACHE;
                end
            end
            OWN_ICACHE, OWN_DCACHE: begin
                // release on the response, forces one idle cycle between grants
                if (adapter_resp) begin
                    next_state = OWN_NONE;
                end
            end
            default: begin
                next_state = OWN_NONE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= OWN_NONE;
        end else begin
            state <= next_state;
        end
    end

    // request and response steering for the owner
    always_comb begin
        icache_resp     = 1'b0;
        icache_rdata    = '0;
        dcache_resp     = 1'b0;
        dcache_rdata    = '0;
        adapter_read    = 1'b0;
        adapter_write   = 1'b0;
        adapter_address = '0;
        adapter_wdata   = '0;

        case (state)
            OWN_ICACHE: begin
                adapter_read    = icache_read;
                adapter_address = icache_address;
                icache_resp     = adapter_resp;
                icache_rdata    = adapter_rdata;
            end
            OWN_DCACHE: begin
                adapter_address = dcache_address;
                dcache_resp     = adapter_resp;
                // read takes precedence if both strobes show up
                if (dcache_read) begin
                    adapter_read = 1'b1;
                    dcache_rdata = adapter_rdata;
                end else if (dcache_write) begin
                    adapter_write = 1'b1;
                    adapter_wdata = dcache_wdata;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// File: design/cacheline_adapter.sv
`timescale 1ns/1ps

module cacheline_adapter
    import mem_line_pkg::*;
    import mem_burst_pkg::*;
(
    input  logic   clk,
    input  logic   rst,

    // line side, driven by the arbiter
    input  logic   adapter_read,
    input  logic   adapter_write,
    input  addr_t  adapter_address,
    input  line_t  adapter_wdata,
    output logic   adapter_resp,
    output line_t  adapter_rdata,

    // burst side, towards memory
    output logic   mem_read,
    output logic   mem_write,
    output addr_t  mem_address,
    output beat_t  mem_wdata,
    input  logic   mem_resp,
    input  beat_t  mem_rdata
);

    localparam int BEAT_BITS = $bits(beat_t);
    localparam beat_idx_t LAST_BEAT = beat_idx_t'(BURST_BEATS - 1);

    // mask that clears the byte offset inside a line
    localparam addr_t LINE_MASK = ~addr_t'((1 << LINE_OFFSET_BITS) - 1);

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_BURST  = 2'd1,
        ST_DONE   = 2'd2,
        ST_SETTLE = 2'd3
    } adapter_state_t;

    adapter_state_t state;
    adapter_state_t next_state;

    logic       dir_write;
    addr_t      line_addr;
    line_t      line_buf;
    beat_idx_t  beat_idx;
    logic       start;
    logic       last_beat;

    assign start     = adapter_read | adapter_write;
    assign last_beat = mem_resp && (beat_idx == LAST_BEAT);

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    next_state = ST_BURST;
                end
            end
            ST_BURST: begin
                if (last_beat) begin
                    next_state = ST_DONE;
                end
            end
            ST_DONE: begin
                next_state = ST_SETTLE;
            end
            // arbiter drops its grant here, so the stale request is not seen
            ST_SETTLE: begin
                next_state = ST_IDLE;
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            dir_write <= 1'b0;
            beat_idx  <= '0;
        end else begin
            state <= next_state;
            if (state == ST_IDLE && start) begin
                dir_write <= adapter_write & ~adapter_read;
                beat_idx  <= '0;
            end else if (state == ST_BURST && mem_resp) begin
                beat_idx <= beat_idx + 1'b1;
            end
        end
    end

    // address and line payload
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            line_addr <= adapter_address & LINE_MASK;
            line_buf  <= adapter_wdata;
        end else if (state == ST_BURST && mem_resp) begin
            if (dir_write) begin
                // next outgoing beat moves down into the low bits
                line_buf <= {beat_t'(0), line_buf[$bits(line_t)-1:BEAT_BITS]};
            end else begin
                line_buf[beat_idx*BEAT_BITS +: BEAT_BITS] <= mem_rdata;
            end
        end
    end

    assign mem_read    = (state == ST_BURST) && !dir_write;
    assign mem_write   = (state == ST_BURST) && dir_write;
    assign mem_address = line_addr;
    assign mem_wdata   = line_buf[BEAT_BITS-1:0];

    assign adapter_resp  = (state == ST_DONE);
    assign adapter_rdata = line_buf;

endmodule

// File: design/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem
    import mem_line_pkg::*;
    import mem_burst_pkg::*;
#(
    parameter bit DCACHE_FIRST = 1'b1
) (
    input  logic   clk,
    input  logic   rst,

    // instruction cache
    input  logic   icache_read,
    input  addr_t  icache_address,
    output logic   icache_resp,
    output line_t  icache_rdata,

    // data cache
    input  logic   dcache_read,
    input  logic   dcache_write,
    input  addr_t  dcache_address,
    input  line_t  dcache_wdata,
    output logic   dcache_resp,
    output line_t  dcache_rdata,

    // external burst memory
    output logic   mem_read,
    output logic   mem_write,
    output addr_t  mem_address,
    output beat_t  mem_wdata,
    input  logic   mem_resp,
    input  beat_t  mem_rdata
);

    // granted line transfer between arbiter and adapter
    logic   adapter_read;
    logic   adapter_write;
    addr_t  adapter_address;
    line_t  adapter_wdata;
    logic   adapter_resp;
    line_t  adapter_rdata;

    line_arbiter #(
        .DCACHE_FIRST(DCACHE_FIRST)
    ) line_arbiter_inst (
        .clk             (clk),
        .rst             (rst),
        .icache_read     (icache_read),
        .icache_address  (icache_address),
        .icache_resp     (icache_resp),
        .icache_rdata    (icache_rdata),
        .dcache_read     (dcache_read),
        .dcache_write    (dcache_write),
        .dcache_address  (dcache_address),
        .dcache_wdata    (dcache_wdata),
        .dcache_resp     (dcache_resp),
        .dcache_rdata    (dcache_rdata),
        .adapter_resp    (adapter_resp),
        .adapter_rdata   (adapter_rdata),
        .adapter_read    (adapter_read),
        .adapter_write   (adapter_write),
        .adapter_address (adapter_address),
        .adapter_wdata   (adapter_wdata)
    );

    cacheline_adapter cacheline_adapter_inst (
        .clk             (clk),
        .rst             (rst),
        .adapter_read    (adapter_read),
        .adapter_write   (adapter_write),
        .adapter_address (adapter_address),
        .adapter_wdata   (adapter_wdata),
        .adapter_resp    (adapter_resp),
        .adapter_rdata   (adapter_rdata),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_resp        (mem_resp),
        .mem_rdata       (mem_rdata)
    );

endmodule

// File: tests/burst_mem_model.sv
`timescale 1ns/1ps

module burst_mem_model
    import mem_line_pkg::*;
    import mem_burst_pkg::*;
#(
    parameter int INDEX_BITS = 6
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   mem_read,
    input  logic   mem_write,
    input  addr_t  mem_address,
    input  beat_t  mem_wdata,
    output logic   mem_resp,
    output beat_t  mem_rdata
);

    localparam int LINE_COUNT = 1 << INDEX_BITS;
    localparam int BEAT_BITS = $bits(beat_t);

    line_t                 lines [LINE_COUNT];
    beat_idx_t             beat_idx;
    int                    stall_left;
    logic [INDEX_BITS-1:0] index;

    assign index = mem_address[LINE_OFFSET_BITS +: INDEX_BITS];

    // all outputs change on the falling edge, the adapter samples on the rising one
    initial begin
        logic [31:0] word_addr;
        // every 32-bit word starts as a hash of its own byte address
        for (int i = 0; i < LINE_COUNT; i++) begin
            for (int w = 0; w < $bits(line_t) / 32; w++) begin
                word_addr = 32'((i << LINE_OFFSET_BITS) + w * 4);
                lines[i][w*32 +: 32] = (word_addr * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
            end
        end
        mem_resp   = 1'b0;
        mem_rdata  = '0;
        beat_idx   = '0;
        stall_left = 0;
        forever begin
            @(negedge clk);
            if (rst) begin
                mem_resp   = 1'b0;
                beat_idx   = '0;
                stall_left = int'($urandom_range(3, 0));
            end else if ((mem_read || mem_write) && stall_left == 0) begin
                // write beat is stable now and gets accepted at the next edge
                if (mem_write) begin
                    lines[index][beat_idx*BEAT_BITS +: BEAT_BITS] = mem_wdata;
                end else begin
                    mem_rdata = lines[index][beat_idx*BEAT_BITS +: BEAT_BITS];
                end
                mem_resp   = 1'b1;
                beat_idx   = beat_idx + 1'b1;
                stall_left = int'($urandom_range(3, 0));
            end else begin
                mem_resp = 1'b0;
                if (mem_read || mem_write) begin
                    stall_left = stall_left - 1;
                end
            end
        end
    end

endmodule

// File: tests/mem_subsystem_properties.sv
`timescale 1ns/1ps

module mem_subsystem_properties
    import mem_line_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   icache_resp,
    input  logic   dcache_resp,
    input  logic   mem_read,
    input  logic   mem_write,
    input  addr_t  mem_address,
    input  logic   adapter_resp
);

    // only the owner of the shared port gets a response
    resp_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(icache_resp && dcache_resp)
    ) else $error("icache_resp and dcache_resp are high in the same cycle");

    strobe_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(mem_read && mem_write)
    ) else $error("mem_read and mem_write are high in the same cycle");

    // burst address is latched once per line
    address_stable: assert property (
        @(posedge clk) disable iff (rst)
        (mem_read || mem_write) |=> (!(mem_read || mem_write) || $stable(mem_address))
    ) else $error("mem_address changed while a strobe was held");

    // memory only ever sees whole lines
    address_aligned: assert property (
        @(posedge clk) disable iff (rst)
        (mem_read || mem_write) |-> (mem_address[LINE_OFFSET_BITS-1:0] == '0)
    ) else $error("mem_address is not line aligned during a burst");

    resp_single_cycle: assert property (
        @(posedge clk) disable iff (rst) adapter_resp |=> !adapter_resp
    ) else $error("adapter_resp stayed high for two cycles");

endmodule

bind mem_subsystem mem_subsystem_properties mem_subsystem_properties_inst (
    .clk          (clk),
    .rst          (rst),
    .icache_resp  (icache_resp),
    .dcache_resp  (dcache_resp),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .mem_address  (mem_address),
    .adapter_resp (adapter_resp)
);

// File: tests/mem_subsystem_tb.sv
`timescale 1ns/1ps

module mem_subsystem_tb
    import mem_line_pkg::*;
    import mem_burst_pkg::*;
();

    localparam int INDEX_BITS = 6;
    localparam int LINE_COUNT = 1 << INDEX_BITS;
    localparam int TIMEOUT_CYCLES = 200;

    logic   clk = 1'b0;
    logic   rst;
    logic   icache_read;
    addr_t  icache_address;
    logic   icache_resp;
    line_t  icache_rdata;
    logic   dcache_read;
    logic   dcache_write;
    addr_t  dcache_address;
    line_t  dcache_wdata;
    logic   dcache_resp;
    line_t  dcache_rdata;
    logic   mem_read;
    logic   mem_write;
    addr_t  mem_address;
    beat_t  mem_wdata;
    logic   mem_resp;
    beat_t  mem_rdata;

    // expected memory contents, updated when a write response arrives
    line_t  model_mem [LINE_COUNT];
    owner_t first_done;
    int     pass_count;
    int     fail_count;
    int     test_start;

    always #4 clk = ~clk;

    mem_subsystem #(
        .DCACHE_FIRST(1'b1)
    ) mem_subsystem_inst (
        .clk(clk), .rst(rst),
        .icache_read(icache_read), .icache_address(icache_address),
        .icache_resp(icache_resp), .icache_rdata(icache_rdata),
        .dcache_read(dcache_read), .dcache_write(dcache_write),
        .dcache_address(dcache_address), .dcache_wdata(dcache_wdata),
        .dcache_resp(dcache_resp), .dcache_rdata(dcache_rdata),
        .mem_read(mem_read), .mem_write(mem_write), .mem_address(mem_address),
        .mem_wdata(mem_wdata), .mem_resp(mem_resp), .mem_rdata(mem_rdata)
    );

    burst_mem_model #(
        .INDEX_BITS(INDEX_BITS)
    ) burst_mem_model_inst (
        .clk(clk), .rst(rst),
        .mem_read(mem_read), .mem_write(mem_write), .mem_address(mem_address),
        .mem_wdata(mem_wdata), .mem_resp(mem_resp), .mem_rdata(mem_rdata)
    );

    function automatic int line_of(input addr_t addr);
        return int'(addr[LINE_OFFSET_BITS +: INDEX_BITS]);
    endfunction

    function automatic addr_t neighbor_line(input addr_t addr, input int step);
        return addr_t'(((line_of(addr) + step + LINE_COUNT) % LINE_COUNT) << LINE_OFFSET_BITS);
    endfunction

    // word value is a hash of its byte address
    function automatic line_t initial_line(input int index);
        line_t       l;
        logic [31:0] word_addr;
        for (int w = 0; w < $bits(line_t) / 32; w++) begin
            word_addr = 32'((index << LINE_OFFSET_BITS) + w * 4);
            l[w*32 +: 32] = (word_addr * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
        end
        return l;
    endfunction

    function automatic line_t random_line();
        line_t l;
        for (int w = 0; w < $bits(line_t) / 32; w++) begin
            l[w*32 +: 32] = $urandom();
        end
        return l;
    endfunction

    // random line plus a random byte offset the adapter has to drop
    function automatic addr_t random_address();
        return addr_t'($urandom_range((LINE_COUNT << LINE_OFFSET_BITS) - 1, 0));
    endfunction

    function automatic owner_t responder();
        if (dcache_resp) begin
            return OWN_DCACHE;
        end else if (icache_resp) begin
            return OWN_ICACHE;
        end
        return OWN_NONE;
    endfunction

    task automatic check_line(input line_t got, input line_t expected, input string what);
        if (got === expected) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, expected);
        end
    endtask

    task automatic check_owner(input owner_t got, input owner_t expected, input string what);
        if (got === expected) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("mismatch at %0t ns: %s got %s expected %s",
                     $time, what, got.name(), expected.name());
        end
    endtask

    task automatic report_timeout(input string what);
        fail_count++;
        $display("no %s within %0d cycles at %0t ns", what, TIMEOUT_CYCLES, $time);
    endtask

    task automatic note_finish(input owner_t who);
        if (first_done == OWN_NONE) begin
            first_done = who;
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %-22s %s", name, (fail_count == test_start) ? "ok" : "errors");
        test_start = fail_count;
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic icache_access(input addr_t addr);
        int    waited;
        bit    seen;
        line_t got;
        icache_read    = 1'b1;
        icache_address = addr;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
            if (icache_resp) begin
                seen = 1'b1;
                got  = icache_rdata;
            end
        end
        if (seen) begin
            note_finish(OWN_ICACHE);
            check_line(got, model_mem[line_of(addr)], "icache_rdata");
            // request stays up through the pulse cycle
            @(negedge clk);
        end else begin
            report_timeout("icache_resp");
        end
        icache_read = 1'b0;
    endtask

    task automatic dcache_access(input bit write, input addr_t addr, input line_t wdata);
        int    waited;
        bit    seen;
        line_t got;
        dcache_read    = !write;
        dcache_write   = write;
        dcache_address = addr;
        dcache_wdata   = wdata;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
            if (dcache_resp) begin
                seen = 1'b1;
                got  = dcache_rdata;
            end
        end
        if (seen) begin
            note_finish(OWN_DCACHE);
            if (write) begin
                model_mem[line_of(addr)] = wdata;
            end else begin
                check_line(got, model_mem[line_of(addr)], "dcache_rdata");
            end
            @(negedge clk);
        end else begin
            report_timeout("dcache_resp");
        end
        dcache_read  = 1'b0;
        dcache_write = 1'b0;
    endtask

    task automatic run_icache_stream(input int count);
        for (int n = 0; n < count; n++) begin
            repeat ($urandom_range(3, 0)) @(negedge clk);
            icache_access(random_address());
        end
    endtask

    task automatic run_dcache_stream(input int count);
        bit write;
        for (int n = 0; n < count; n++) begin
            repeat ($urandom_range(3, 0)) @(negedge clk);
            write = ($urandom_range(1, 0) == 1);
            dcache_access(write, random_address(), random_line());
        end
    endtask

    initial begin
        addr_t a;
        addr_t b;
        line_t w;
        void'($urandom(48));
        rst            = 1'b1;
        icache_read    = 1'b0;
        icache_address = '0;
        dcache_read    = 1'b0;
        dcache_write   = 1'b0;
        dcache_address = '0;
        dcache_wdata   = '0;
        first_done     = OWN_NONE;
        pass_count     = 0;
        fail_count     = 0;
        test_start     = 0;
        for (int i = 0; i < LINE_COUNT; i++) begin
            model_mem[i] = initial_line(i);
        end

        repeat (16) begin
            @(negedge clk);
            check_owner(responder(), OWN_NONE, "response during reset");
        end
        rst = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_owner(responder(), OWN_NONE, "response before any request");
        end
        finish_test("reset quiet");

        repeat (20) begin
            icache_access(random_address());
        end
        finish_test("instruction reads");

        repeat (6) begin
            a = random_address();
            w = random_line();
            dcache_access(1'b1, a, w);
            dcache_access(1'b0, a, '0);
            icache_access(neighbor_line(a, 1));
            dcache_access(1'b0, neighbor_line(a, -1), '0);
        end
        finish_test("data write then read");

        // both requests rise on the same falling edge
        for (int k = 0; k < 4; k++) begin
            a = random_address();
            b = random_address();
            w = random_line();
            first_done = OWN_NONE;
            fork
                icache_access(a);
                dcache_access(k[0], b, w);
            join
            check_owner(first_done, OWN_DCACHE, "first response");
        end
        finish_test("priority");

        fork
            run_icache_stream(100);
            run_dcache_stream(100);
        join
        finish_test("mixed traffic");

        $display("%0d checks passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: src.f
design/mem_line_pkg.sv
design/mem_burst_pkg.sv
design/line_arbiter.sv
design/cacheline_adapter.sv
design/mem_subsystem.sv
tests/burst_mem_model.sv
tests/mem_subsystem_properties.sv
tests/mem_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f src.f --top-module mem_subsystem_tb \
    -o mem_subsystem_sim > build.log 2>&1 \
    && ./obj_dir/mem_subsystem_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0
